//--- filelist.f
hdl/tmu_pkg.sv
hdl/tmu_quad_if.sv
hdl/tmu_desc_table.sv
hdl/tmu_addr_gen.sv
hdl/tmu_texel_decode.sv
hdl/tmu_fetch_ctrl.sv
hdl/tmu_bilerp.sv
hdl/tmu_top.sv
verif/tmu_chk.sv
verif/tmu_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tmu_tb
FILELIST   = filelist.f
SIM_ARGS   = +verilator+error+limit+10
PASS_MSG   = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- verif/tmu_tb.sv
// Testbench for the texture sampling unit
// Clock, reset, descriptor setup, cache memory model and random samples
// Reference colour model and the result compare process

`timescale 1ns/10ps
`default_nettype none

module tmu_tb;
    import tmu_pkg::*;

    localparam int MEM_AW    = 15;
    localparam int MEM_BYTES = 1 << MEM_AW;
    localparam int MAX_WAIT  = 100;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        desc_wr;
    logic [SAMPLER_WIDTH-1:0]    desc_sel;
    logic [ADDR_WIDTH-1:0]       desc_base;
    logic [DIM_WIDTH-1:0]        desc_width;
    logic [DIM_WIDTH-1:0]        desc_height;
    tex_format_t                 desc_format;
    filter_mode_t                desc_filter;
    wrap_mode_t                  desc_wrap_u;
    wrap_mode_t                  desc_wrap_v;
    logic                        sample_req;
    logic                        sample_ready;
    logic [SAMPLER_WIDTH-1:0]    sampler_id;
    logic [COORD_WIDTH-1:0]      coord_u;
    logic [COORD_WIDTH-1:0]      coord_v;
    logic                        sample_valid;
    rgba8_t                      sample_data;
    logic                        tcache_req;
    logic [ADDR_WIDTH-1:0]       tcache_addr;
    logic                        tcache_valid = 1'b0;
    logic [CACHE_DATA_WIDTH-1:0] tcache_data  = '0;

    logic [7:0]  mem [0:MEM_BYTES-1];
    tex_desc_t   descs [NUM_SAMPLERS];
    rgba8_t      exp_q [$];
    int unsigned wait_left  = 0;
    int          n_checked  = 0;

    always #10 clk = ~clk;

    tmu_top dut0 (
        .clk, .rst_n, .desc_wr, .desc_sel, .desc_base, .desc_width, .desc_height,
        .desc_format, .desc_filter, .desc_wrap_u, .desc_wrap_v,
        .sample_req, .sample_ready, .sampler_id, .coord_u, .coord_v,
        .sample_valid, .sample_data,
        .tcache_req, .tcache_addr, .tcache_valid, .tcache_data
    );

    // Checker sees the real filter output pulse next to the fetch handshakes
    bind tmu_top tmu_chk u_chk (
        .clk, .rst_n, .sample_req, .sample_ready, .sample_valid,
        .tcache_req, .tcache_addr, .tcache_valid
    );

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
        logic [MEM_AW-1:0] a;
        a = addr[MEM_AW-1:0];
        // Little endian
        return {mem[a + MEM_AW'(3)], mem[a + MEM_AW'(2)], mem[a + MEM_AW'(1)], mem[a]};
    endfunction

    function automatic rgba8_t decode_ref(input tex_format_t fmt, input logic [31:0] raw);
        rgba8_t     c;
        logic [7:0] r5, g6, b5;
        r5 = {3'b000, raw[4:0]};
        g6 = {2'b00, raw[10:5]};
        b5 = {3'b000, raw[15:11]};
        case (fmt)
            FMT_RGB565: c = '{r: (r5 << 3) | (r5 >> 2), g: (g6 << 2) | (g6 >> 4),
                              b: (b5 << 3) | (b5 >> 2), a: 8'hFF};
            FMT_R8:     c = '{r: raw[7:0], g: 8'h00, b: 8'h00, a: 8'hFF};
            default:    c = '{r: raw[7:0], g: raw[15:8], b: raw[23:16], a: raw[31:24]};
        endcase
        return c;
    endfunction

    function automatic rgba8_t corner(input tex_desc_t d, input int unsigned col,
                                      input int unsigned row);
        int unsigned sz;
        sz = (d.format == FMT_RGBA8) ? 4 : (d.format == FMT_RGB565) ? 2 : 1;
        return decode_ref(d.format, mem_word(d.base + (row * 32'(d.width) + col) * sz));
    endfunction

    function automatic logic [7:0] mix(input logic [7:0] c0, input logic [7:0] c1,
                                       input logic [7:0] c2, input logic [7:0] c3,
                                       input int unsigned k0, input int unsigned k1,
                                       input int unsigned k2, input int unsigned k3);
        return 8'((k0 * c0 + k1 * c1 + k2 * c2 + k3 * c3) / 256);
    endfunction

    function automatic rgba8_t exp_sample(input tex_desc_t d,
                                          input logic [COORD_WIDTH-1:0] cu,
                                          input logic [COORD_WIDTH-1:0] cv);
        int unsigned su, sv, u0, v0, u1, v1, fu, fv, w, h;
        int unsigned k_tl, k_tr, k_bl, k_br;
        rgba8_t      tl, tr, bl, br, res;
        w  = 32'(d.width);
        h  = 32'(d.height);
        su = (32'(cu) * w) >> 8;
        sv = (32'(cv) * h) >> 8;
        u0 = su >> 8;
        v0 = sv >> 8;
        fu = su & 255;
        fv = sv & 255;
        // Neighbour past the edge wraps to 0 or stays on the edge texel
        u1 = (u0 + 1 < w) ? u0 + 1 : ((d.wrap_u == WRAP_REPEAT) ? 0 : u0);
        v1 = (v0 + 1 < h) ? v0 + 1 : ((d.wrap_v == WRAP_REPEAT) ? 0 : v0);
        tl = corner(d, u0, v0);
        if (d.filter == FILTER_NEAREST)
            return tl;
        tr   = corner(d, u1, v0);
        bl   = corner(d, u0, v1);
        br   = corner(d, u1, v1);
        k_tl = (256 - fu) * (256 - fv) / 256;
        k_tr = fu * (256 - fv) / 256;
        k_bl = (256 - fu) * fv / 256;
        k_br = fu * fv / 256;
        res.r = mix(tl.r, tr.r, bl.r, br.r, k_tl, k_tr, k_bl, k_br);
        res.g = mix(tl.g, tr.g, bl.g, br.g, k_tl, k_tr, k_bl, k_br);
        res.b = mix(tl.b, tr.b, bl.b, br.b, k_tl, k_tr, k_bl, k_br);
        res.a = mix(tl.a, tr.a, bl.a, br.a, k_tl, k_tr, k_bl, k_br);
        return res;
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rgba(input rgba8_t got, input rgba8_t want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t ns %s: got rgba %08h, expected %08h",
                     $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, got, want);
            abort_run();
        end
    endtask

    // ====================
    // Cache memory model
    // ====================
    // Each request answered after zero to three wait cycles
    always @(posedge clk) begin
        if (tcache_valid) begin
            tcache_valid <= 1'b0;
        end else if (tcache_req) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                tcache_valid <= 1'b1;
                tcache_data  <= mem_word(tcache_addr);
                wait_left    <= $urandom_range(3);
            end
        end
    end

    // Assertion failures of the bound checker
    always @(negedge clk) begin
        if (dut0.u_chk.fail_count != 0) begin
            $display("A protocol assertion failed in the fetch controller");
            abort_run();
        end
    end

    // ====================
    // Stimulus
    // ====================
    function automatic tex_desc_t make_desc(input logic [SAMPLER_WIDTH-1:0] slot,
                                            input tex_format_t fmt,
                                            input filter_mode_t filt, input bit odd_dims);
        tex_desc_t d;
        d.base   = 32'(slot) * 32'h2000 + $urandom_range(255);
        d.width  = DIM_WIDTH'(1 + $urandom_range(36));
        d.height = DIM_WIDTH'(1 + $urandom_range(36));
        if (odd_dims) begin
            d.width[0]  = 1'b1;
            d.height[0] = 1'b1;
        end
        d.format = fmt;
        d.filter = filt;
        d.wrap_u = wrap_mode_t'($urandom_range(1));
        d.wrap_v = wrap_mode_t'($urandom_range(1));
        return d;
    endfunction

    task automatic write_desc(input logic [SAMPLER_WIDTH-1:0] slot, input tex_desc_t d);
        descs[slot] = d;
        @(posedge clk);
        desc_wr     <= 1'b1;
        desc_sel    <= slot;
        desc_base   <= d.base;
        desc_width  <= d.width;
        desc_height <= d.height;
        desc_format <= d.format;
        desc_filter <= d.filter;
        desc_wrap_u <= d.wrap_u;
        desc_wrap_v <= d.wrap_v;
        @(posedge clk);
        desc_wr <= 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!sample_ready) begin
            cycles++;
            if (cycles > MAX_WAIT) begin
                $display("Timeout waiting for sample_ready");
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic run_sample(input logic [SAMPLER_WIDTH-1:0] sid,
                              input logic [COORD_WIDTH-1:0] cu,
                              input logic [COORD_WIDTH-1:0] cv);
        wait_ready();
        @(posedge clk);
        sample_req <= 1'b1;
        sampler_id <= sid;
        coord_u    <= cu;
        coord_v    <= cv;
        // Accepted at this edge
        @(posedge clk);
        sample_req <= 1'b0;
        exp_q.push_back(exp_sample(descs[sid], cu, cv));
    endtask

    initial begin : stimulus
        int cycles;
        rst_n       = 1'b0;
        desc_wr     = 1'b0;
        desc_sel    = '0;
        desc_base   = '0;
        desc_width  = '0;
        desc_height = '0;
        desc_format = FMT_RGBA8;
        desc_filter = FILTER_NEAREST;
        desc_wrap_u = WRAP_REPEAT;
        desc_wrap_v = WRAP_REPEAT;
        sample_req  = 1'b0;
        sampler_id  = '0;
        coord_u     = '0;
        coord_v     = '0;
        void'($urandom(32'ha6cc));
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[MEM_AW'(i)] = 8'($urandom);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Nearest, one format at a time
        for (int f = 0; f < 3; f++) begin
            write_desc(0, make_desc(0, tex_format_t'(f), FILTER_NEAREST, 1'b0));
            repeat (20) run_sample(0, 16'($urandom), 16'($urandom));
        end

        // Bilinear on random textures
        repeat (15) begin
            write_desc(1, make_desc(1, tex_format_t'($urandom_range(2)),
                                    FILTER_BILINEAR, 1'b0));
            repeat (4) run_sample(1, 16'($urandom), 16'($urandom));
        end

        // Right and bottom edges on odd sizes
        repeat (15) begin
            write_desc(2, make_desc(2, tex_format_t'($urandom_range(2)),
                                    FILTER_BILINEAR, 1'b1));
            repeat (4) run_sample(2, 16'hFF00 | 16'($urandom_range(255)),
                                  16'hFF00 | 16'($urandom_range(255)));
        end

        // All samplers in random order
        for (int s = 0; s < NUM_SAMPLERS; s++) begin
            write_desc(SAMPLER_WIDTH'(s), make_desc(SAMPLER_WIDTH'(s),
                       tex_format_t'(s % 3), filter_mode_t'(s % 2), 1'b0));
        end
        repeat (80) run_sample(SAMPLER_WIDTH'($urandom_range(3)),
                               16'($urandom), 16'($urandom));

        cycles = 0;
        while (exp_q.size() != 0) begin
            cycles++;
            if (cycles > MAX_WAIT) begin
                $display("Timeout waiting for the last samples to complete");
                abort_run();
            end
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("Checked %0d samples", n_checked);
        if (dut0.u_chk.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("A protocol assertion failed in the fetch controller");
            abort_run();
        end
    end

    // ====================
    // Compare process
    // ====================
    initial begin : compare
        rgba8_t want;
        int     cycles;
        forever begin
            @(negedge clk);
            if (exp_q.size() == 0) begin
                if (sample_valid) begin
                    $display("sample_valid pulsed with no sample outstanding");
                    abort_run();
                end
            end else begin
                want   = exp_q.pop_front();
                cycles = 0;
                while (!sample_valid) begin
                    check_flag(sample_ready, 1'b0, "sample_ready while busy");
                    cycles++;
                    if (cycles > MAX_WAIT) begin
                        $display("Timeout waiting for sample_valid");
                        abort_run();
                    end
                    @(negedge clk);
                end
                check_rgba(sample_data, want, "sample_data");
                n_checked++;
                @(negedge clk);
                check_flag(sample_valid, 1'b0, "sample_valid after one cycle");
                check_flag(sample_ready, 1'b1, "sample_ready after result");
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tmu_chk.sv
// Protocol assertions on the sample and cache ports
// Cache request hold, result pulse width, busy window of sample_ready

`timescale 1ns/10ps
`default_nettype none

module tmu_chk (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           sample_req,
    input logic                           sample_ready,
    input logic                           sample_valid,
    input logic                           tcache_req,
    input logic [tmu_pkg::ADDR_WIDTH-1:0] tcache_addr,
    input logic                           tcache_valid
);

    int unsigned fail_count = 0;
    logic        busy;

    // Open from acceptance until the result pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy <= 1'b0;
        else if (sample_req && sample_ready)
            busy <= 1'b1;
        else if (sample_valid)
            busy <= 1'b0;
    end

    hold_addr: assert property (@(posedge clk) disable iff (!rst_n)
        tcache_req && !tcache_valid |=> tcache_req && $stable(tcache_addr))
        else begin
            fail_count++;
            $error("tcache_addr or tcache_req changed before tcache_valid");
        end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else begin
            fail_count++;
            $error("sample_valid held for two cycles");
        end

    ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !sample_ready)
        else begin
            fail_count++;
            $error("sample_ready high while a sample is in flight");
        end

    // Every result belongs to an accepted request
    valid_owned: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> busy)
        else begin
            fail_count++;
            $error("sample_valid without an accepted request");
        end

endmodule

`default_nettype wire

//--- hdl/tmu_top.sv
// Texture sampling unit top level
// Descriptor table, fetch controller, address generator, decoder, filter

`timescale 1ns/10ps
`default_nettype none

module tmu_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 desc_wr,
    input  logic [tmu_pkg::SAMPLER_WIDTH-1:0]    desc_sel,
    input  logic [tmu_pkg::ADDR_WIDTH-1:0]       desc_base,
    input  logic [tmu_pkg::DIM_WIDTH-1:0]        desc_width,
    input  logic [tmu_pkg::DIM_WIDTH-1:0]        desc_height,
    input  tmu_pkg::tex_format_t                 desc_format,
    input  tmu_pkg::filter_mode_t                desc_filter,
    input  tmu_pkg::wrap_mode_t                  desc_wrap_u,
    input  tmu_pkg::wrap_mode_t                  desc_wrap_v,
    input  logic                                 sample_req,
    output logic                                 sample_ready,
    input  logic [tmu_pkg::SAMPLER_WIDTH-1:0]    sampler_id,
    input  logic [tmu_pkg::COORD_WIDTH-1:0]      coord_u,
    input  logic [tmu_pkg::COORD_WIDTH-1:0]      coord_v,
    output logic                                 sample_valid,
    output tmu_pkg::rgba8_t                      sample_data,
    output logic                                 tcache_req,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]       tcache_addr,
    input  logic                                 tcache_valid,
    input  logic [tmu_pkg::CACHE_DATA_WIDTH-1:0] tcache_data
);
    import tmu_pkg::*;

    tex_desc_t                wr_desc, rd_desc, desc_q;
    logic [SAMPLER_WIDTH-1:0] rd_sel;
    logic [COORD_WIDTH-1:0]   coord_u_q, coord_v_q;
    logic [ADDR_WIDTH-1:0]    addr_tl, addr_tr, addr_bl, addr_br;
    logic [FRAC_WIDTH-1:0]    frac_u, frac_v;
    rgba8_t                   texel;

    tmu_quad_if quad_bus ();

    // Descriptor write fields gathered into one slot word
    assign wr_desc.base   = desc_base;
    assign wr_desc.width  = desc_width;
    assign wr_desc.height = desc_height;
    assign wr_desc.format = desc_format;
    assign wr_desc.filter = desc_filter;
    assign wr_desc.wrap_u = desc_wrap_u;
    assign wr_desc.wrap_v = desc_wrap_v;

    tmu_desc_table u_desc_table (
        .clk, .rst_n, .desc_wr, .desc_sel,
        .desc_in (wr_desc),
        .rd_sel,
        .rd_desc
    );

    tmu_fetch_ctrl u_fetch_ctrl (
        .clk, .rst_n, .sample_req, .sample_ready, .sampler_id, .coord_u, .coord_v,
        .rd_sel, .rd_desc, .desc_q, .coord_u_q, .coord_v_q,
        .addr_tl, .addr_tr, .addr_bl, .addr_br, .frac_u, .frac_v,
        .tcache_req, .tcache_addr, .tcache_valid, .texel,
        .quad    (quad_bus.producer)
    );

    tmu_addr_gen u_addr_gen (
        .desc    (desc_q),
        .coord_u (coord_u_q),
        .coord_v (coord_v_q),
        .addr_tl, .addr_tr, .addr_bl, .addr_br, .frac_u, .frac_v
    );

    tmu_texel_decode u_texel_decode (
        .format  (desc_q.format),
        .raw     (tcache_data),
        .texel
    );

    tmu_bilerp u_bilerp (
        .clk, .rst_n,
        .quad    (quad_bus.consumer),
        .sample_valid, .sample_data
    );

endmodule

`default_nettype wire

//--- hdl/tmu_bilerp.sv
// Quad filter
// Bilinear weights, per-channel blend or nearest pass, registered result

`timescale 1ns/10ps
`default_nettype none

module tmu_bilerp (
    input  logic            clk,
    input  logic            rst_n,
    tmu_quad_if.consumer    quad,
    output logic            sample_valid,
    output tmu_pkg::rgba8_t sample_data
);
    import tmu_pkg::*;

    typedef logic [2*FRAC_WIDTH+1:0] acc_t;

    logic [FRAC_WIDTH:0] inv_u, inv_v;
    acc_t                w_tl, w_tr, w_bl, w_br;
    rgba8_t              blended;

    // Weighted sum of one channel, weights total at most 256
    function automatic logic [7:0] blend(
        input logic [7:0] c_tl,
        input logic [7:0] c_tr,
        input logic [7:0] c_bl,
        input logic [7:0] c_br,
        input acc_t       k_tl,
        input acc_t       k_tr,
        input acc_t       k_bl,
        input acc_t       k_br
    );
        acc_t acc;
        acc = acc_t'(c_tl) * k_tl + acc_t'(c_tr) * k_tr +
              acc_t'(c_bl) * k_bl + acc_t'(c_br) * k_br;
        return acc[FRAC_WIDTH +: 8];
    endfunction

    // ====================
    // Weights and blend
    // ====================
    always_comb begin
        inv_u = {1'b1, {FRAC_WIDTH{1'b0}}} - {1'b0, quad.frac_u};
        inv_v = {1'b1, {FRAC_WIDTH{1'b0}}} - {1'b0, quad.frac_v};
        w_tl  = (acc_t'(inv_u) * acc_t'(inv_v)) >> FRAC_WIDTH;
        w_tr  = (acc_t'(quad.frac_u) * acc_t'(inv_v)) >> FRAC_WIDTH;
        w_bl  = (acc_t'(inv_u) * acc_t'(quad.frac_v)) >> FRAC_WIDTH;
        w_br  = (acc_t'(quad.frac_u) * acc_t'(quad.frac_v)) >> FRAC_WIDTH;

        blended.r = blend(quad.tl.r, quad.tr.r, quad.bl.r, quad.br.r, w_tl, w_tr, w_bl, w_br);
        blended.g = blend(quad.tl.g, quad.tr.g, quad.bl.g, quad.br.g, w_tl, w_tr, w_bl, w_br);
        blended.b = blend(quad.tl.b, quad.tr.b, quad.bl.b, quad.br.b, w_tl, w_tr, w_bl, w_br);
        blended.a = blend(quad.tl.a, quad.tr.a, quad.bl.a, quad.br.a, w_tl, w_tr, w_bl, w_br);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= quad.quad_valid;
    end

    // Nearest passes the top-left texel untouched
    always_ff @(posedge clk) begin
        if (quad.quad_valid)
            sample_data <= quad.nearest ? quad.tl : blended;
    end

endmodule

`default_nettype wire

//--- hdl/tmu_fetch_ctrl.sv
// Sample fetch controller
// Request capture, quad fetch FSM, cache requests and texel collection

`timescale 1ns/10ps
`default_nettype none

module tmu_fetch_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sample_req,
    output logic                              sample_ready,
    input  logic [tmu_pkg::SAMPLER_WIDTH-1:0] sampler_id,
    input  logic [tmu_pkg::COORD_WIDTH-1:0]   coord_u,
    input  logic [tmu_pkg::COORD_WIDTH-1:0]   coord_v,
    output logic [tmu_pkg::SAMPLER_WIDTH-1:0] rd_sel,
    input  tmu_pkg::tex_desc_t                rd_desc,
    output tmu_pkg::tex_desc_t                desc_q,
    output logic [tmu_pkg::COORD_WIDTH-1:0]   coord_u_q,
    output logic [tmu_pkg::COORD_WIDTH-1:0]   coord_v_q,
    input  logic [tmu_pkg::ADDR_WIDTH-1:0]    addr_tl,
    input  logic [tmu_pkg::ADDR_WIDTH-1:0]    addr_tr,
    input  logic [tmu_pkg::ADDR_WIDTH-1:0]    addr_bl,
    input  logic [tmu_pkg::ADDR_WIDTH-1:0]    addr_br,
    input  logic [tmu_pkg::FRAC_WIDTH-1:0]    frac_u,
    input  logic [tmu_pkg::FRAC_WIDTH-1:0]    frac_v,
    output logic                              tcache_req,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]    tcache_addr,
    input  logic                              tcache_valid,
    input  tmu_pkg::rgba8_t                   texel,
    tmu_quad_if.producer                      quad
);
    import tmu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_ADDR, ST_FETCH_TL, ST_FETCH_TR, ST_FETCH_BL, ST_FETCH_BR, ST_QUAD
    } state_t;

    state_t                state, next_state;
    logic                  accept;
    logic                  fetch_done;
    logic                  quad_sent;
    logic [ADDR_WIDTH-1:0] a_tl, a_tr, a_bl, a_br;

    assign sample_ready = (state == ST_IDLE);
    assign accept       = sample_ready && sample_req;
    assign rd_sel       = sampler_id;
    assign fetch_done   = tcache_req && tcache_valid;

    // ====================
    // State machine
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            quad_sent <= 1'b0;
        end else begin
            state     <= next_state;
            quad_sent <= (state == ST_QUAD) && !quad_sent;
        end
    end

    // Quad state holds two cycles, the filter cycle and the result cycle
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:     if (accept) next_state = ST_ADDR;
            ST_ADDR:     next_state = ST_FETCH_TL;
            ST_FETCH_TL: begin
                if (tcache_valid)
                    next_state = (desc_q.filter == FILTER_NEAREST) ? ST_QUAD : ST_FETCH_TR;
            end
            ST_FETCH_TR: if (tcache_valid) next_state = ST_FETCH_BL;
            ST_FETCH_BL: if (tcache_valid) next_state = ST_FETCH_BR;
            ST_FETCH_BR: if (tcache_valid) next_state = ST_QUAD;
            ST_QUAD:     if (quad_sent) next_state = ST_IDLE;
            default:     next_state = ST_IDLE;
        endcase
    end

    // ====================
    // Request and addresses
    // ====================
    always_ff @(posedge clk) begin
        if (accept) begin
            desc_q    <= rd_desc;
            coord_u_q <= coord_u;
            coord_v_q <= coord_v;
        end
        // Corner addresses captured in the address cycle
        if (state == ST_ADDR) begin
            a_tl <= addr_tl;
            a_tr <= addr_tr;
            a_bl <= addr_bl;
            a_br <= addr_br;
        end
    end

    assign tcache_req = (state == ST_FETCH_TL) || (state == ST_FETCH_TR) ||
                        (state == ST_FETCH_BL) || (state == ST_FETCH_BR);

    always_comb begin
        case (state)
            ST_FETCH_TR: tcache_addr = a_tr;
            ST_FETCH_BL: tcache_addr = a_bl;
            ST_FETCH_BR: tcache_addr = a_br;
            default:     tcache_addr = a_tl;
        endcase
    end

    // Decoded texel lands in the corner of the current fetch state
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            case (state)
                ST_FETCH_TL: quad.tl <= texel;
                ST_FETCH_TR: quad.tr <= texel;
                ST_FETCH_BL: quad.bl <= texel;
                ST_FETCH_BR: quad.br <= texel;
                default: ;
            endcase
        end
    end

    assign quad.frac_u     = frac_u;
    assign quad.frac_v     = frac_v;
    assign quad.nearest    = (desc_q.filter == FILTER_NEAREST);
    assign quad.quad_valid = (state == ST_QUAD) && !quad_sent;

endmodule

`default_nettype wire

//--- hdl/tmu_texel_decode.sv
// Texel decoder
// RGBA8, RGB565 and R8 cache words expanded to an RGBA8 colour

`timescale 1ns/10ps
`default_nettype none

module tmu_texel_decode (
    input  tmu_pkg::tex_format_t                 format,
    input  logic [tmu_pkg::CACHE_DATA_WIDTH-1:0] raw,
    output tmu_pkg::rgba8_t                      texel
);
    import tmu_pkg::*;

    always_comb begin
        case (format)
            FMT_RGB565: begin
                // Widen each field by repeating its top bits
                texel.r = {raw[4:0], raw[4:2]};
                texel.g = {raw[10:5], raw[10:9]};
                texel.b = {raw[15:11], raw[15:13]};
                texel.a = 8'hFF;
            end
            FMT_R8: begin
                texel.r = raw[7:0];
                texel.g = 8'h00;
                texel.b = 8'h00;
                texel.a = 8'hFF;
            end
            default: begin
                // Bytes in memory order r, g, b, a
                texel.r = raw[7:0];
                texel.g = raw[15:8];
                texel.b = raw[23:16];
                texel.a = raw[31:24];
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/tmu_addr_gen.sv
// Texel address generator
// Coordinate scaling, neighbour wrap and the four quad corner addresses

`timescale 1ns/10ps
`default_nettype none

module tmu_addr_gen (
    input  tmu_pkg::tex_desc_t              desc,
    input  logic [tmu_pkg::COORD_WIDTH-1:0] coord_u,
    input  logic [tmu_pkg::COORD_WIDTH-1:0] coord_v,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]  addr_tl,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]  addr_tr,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]  addr_bl,
    output logic [tmu_pkg::ADDR_WIDTH-1:0]  addr_br,
    output logic [tmu_pkg::FRAC_WIDTH-1:0]  frac_u,
    output logic [tmu_pkg::FRAC_WIDTH-1:0]  frac_v
);
    import tmu_pkg::*;

    typedef logic [COORD_WIDTH+DIM_WIDTH-1:0] prod_t;

    prod_t                prod_u;
    prod_t                prod_v;
    logic [DIM_WIDTH-1:0] u0, v0, u1, v1;

    // Right or lower neighbour of a texel position
    function automatic logic [DIM_WIDTH-1:0] next_texel(
        input logic [DIM_WIDTH-1:0] pos,
        input logic [DIM_WIDTH-1:0] size,
        input wrap_mode_t           wrap
    );
        logic [DIM_WIDTH:0] inc;
        inc = {1'b0, pos} + 1'b1;
        if (inc < {1'b0, size})
            return inc[DIM_WIDTH-1:0];
        else if (wrap == WRAP_REPEAT)
            return '0;
        else
            return pos;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] texel_addr(
        input tex_desc_t            d,
        input logic [DIM_WIDTH-1:0] col,
        input logic [DIM_WIDTH-1:0] row
    );
        logic [ADDR_WIDTH-1:0] index;
        index = ADDR_WIDTH'(row) * ADDR_WIDTH'(d.width) + ADDR_WIDTH'(col);
        case (d.format)
            FMT_RGBA8:  return d.base + (index << 2);
            FMT_RGB565: return d.base + (index << 1);
            default:    return d.base + index;
        endcase
    endfunction

    // ====================
    // Scale to texel space
    // ====================
    // Coordinate is a 16-bit fraction, so the texel column sits above it
    assign prod_u = prod_t'(coord_u) * prod_t'(desc.width);
    assign prod_v = prod_t'(coord_v) * prod_t'(desc.height);

    assign u0     = prod_u[COORD_WIDTH +: DIM_WIDTH];
    assign v0     = prod_v[COORD_WIDTH +: DIM_WIDTH];
    assign frac_u = prod_u[COORD_WIDTH-FRAC_WIDTH +: FRAC_WIDTH];
    assign frac_v = prod_v[COORD_WIDTH-FRAC_WIDTH +: FRAC_WIDTH];

    always_comb begin
        u1      = next_texel(u0, desc.width, desc.wrap_u);
        v1      = next_texel(v0, desc.height, desc.wrap_v);
        addr_tl = texel_addr(desc, u0, v0);
        addr_tr = texel_addr(desc, u1, v0);
        addr_bl = texel_addr(desc, u0, v1);
        addr_br = texel_addr(desc, u1, v1);
    end

endmodule

`default_nettype wire

//--- hdl/tmu_desc_table.sv
// Texture descriptor register file
// One slot per sampler, written by strobe, read combinationally

`timescale 1ns/10ps
`default_nettype none

module tmu_desc_table (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              desc_wr,
    input  logic [tmu_pkg::SAMPLER_WIDTH-1:0] desc_sel,
    input  tmu_pkg::tex_desc_t                desc_in,
    input  logic [tmu_pkg::SAMPLER_WIDTH-1:0] rd_sel,
    output tmu_pkg::tex_desc_t                rd_desc
);
    import tmu_pkg::*;

    tex_desc_t slots [NUM_SAMPLERS];

    // Slots come up as all-zero descriptors
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SAMPLERS; i++) begin
                slots[i] <= '0;
            end
        end else if (desc_wr) begin
            slots[desc_sel] <= desc_in;
        end
    end

    // Read port for the fetch controller
    assign rd_desc = slots[rd_sel];

endmodule

`default_nettype wire

//--- hdl/tmu_quad_if.sv
// Quad bus from the fetch controller to the filter
// Four decoded texels, filter weights, nearest flag and valid strobe

`timescale 1ns/10ps
`default_nettype none

interface tmu_quad_if;
    import tmu_pkg::*;

    rgba8_t                tl;
    rgba8_t                tr;
    rgba8_t                bl;
    rgba8_t                br;
    logic [FRAC_WIDTH-1:0] frac_u;
    logic [FRAC_WIDTH-1:0] frac_v;
    logic                  nearest;
    // One cycle, texels and weights stable around it
    logic                  quad_valid;

    modport producer (output tl, tr, bl, br, frac_u, frac_v, nearest, quad_valid);
    modport consumer (input tl, tr, bl, br, frac_u, frac_v, nearest, quad_valid);

endinterface

`default_nettype wire

//--- hdl/tmu_pkg.sv
// Widths and sizes shared by the texture sampling unit
// Texture format, filter and wrap encodings
// Texture descriptor and RGBA8 colour structs

`default_nettype none

package tmu_pkg;

    localparam int ADDR_WIDTH       = 32;
    localparam int DIM_WIDTH        = 12;
    localparam int COORD_WIDTH      = 16;
    localparam int FRAC_WIDTH       = 8;
    localparam int NUM_SAMPLERS     = 4;
    localparam int SAMPLER_WIDTH    = 2;
    localparam int CACHE_DATA_WIDTH = 32;

    typedef enum logic [1:0] {
        FMT_RGBA8  = 2'd0,
        FMT_RGB565 = 2'd1,
        FMT_R8     = 2'd2
    } tex_format_t;

    typedef enum logic {
        FILTER_NEAREST  = 1'b0,
        FILTER_BILINEAR = 1'b1
    } filter_mode_t;

    typedef enum logic {
        WRAP_REPEAT = 1'b0,
        WRAP_CLAMP  = 1'b1
    } wrap_mode_t;

    // One texture as seen by a sampler slot
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] base;
        logic [DIM_WIDTH-1:0]  width;
        logic [DIM_WIDTH-1:0]  height;
        tex_format_t           format;
        filter_mode_t          filter;
        wrap_mode_t            wrap_u;
        wrap_mode_t            wrap_v;
    } tex_desc_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] a;
    } rgba8_t;

endpackage

`default_nettype wire
